// ==== hw/istream_pkg.sv ====
package istream_pkg;

	// ------------------------------------------------------------
	// Stage sizes

	// Parcels per fetch chunk
	localparam int FETCH_WIDTH_2B = 8;

	// Instructions handed to decode per cycle
	localparam int WAYS = 4;

	// Chunk entries in the queue
	localparam int ISTREAM_SETS = 4;

	// Head chunk plus the one after it
	localparam int WINDOW_2B = 2 * FETCH_WIDTH_2B;

	// ------------------------------------------------------------
	// Types

	// One 16-bit instruction parcel
	typedef logic [15:0] parcel_t;

	typedef logic [31:0] pc_t;

	// One valid bit per parcel of a chunk
	typedef logic [FETCH_WIDTH_2B-1:0] parcel_mask_t;

	// One bit per parcel of the two-chunk window
	typedef logic [WINDOW_2B-1:0] window_mask_t;

	// Parcel position in the window, 0 to 15
	typedef logic [3:0] parcel_idx_t;

	// Parcel count in the window, 0 to 16
	typedef logic [4:0] parcel_cnt_t;

	// Queue entry index
	typedef logic [1:0] set_ptr_t;

	typedef logic [WAYS-1:0] way_mask_t;

endpackage

// ==== hw/istream_chunk_queue.sv ====
`timescale 1ns/100ps

module istream_chunk_queue (
	input logic CLK,
	input logic nRST,
	input logic restart,

	// Enqueue side
	input logic enq,
	input istream_pkg::parcel_mask_t enq_mask,
	input istream_pkg::parcel_t [istream_pkg::FETCH_WIDTH_2B-1:0] enq_parcels,
	input istream_pkg::pc_t enq_after_PC,

	// Dequeue side
	input logic consume,
	input istream_pkg::parcel_cnt_t consume_count,

	output logic full,
	output istream_pkg::window_mask_t window_valid,
	output istream_pkg::parcel_t [istream_pkg::WINDOW_2B-1:0] window_parcels,
	output istream_pkg::pc_t [1:0] window_base_PC,
	output istream_pkg::parcel_idx_t read_offset
);

	// Chunk storage
	istream_pkg::parcel_t [istream_pkg::FETCH_WIDTH_2B-1:0] parcels_q [istream_pkg::ISTREAM_SETS];
	istream_pkg::parcel_mask_t mask_q [istream_pkg::ISTREAM_SETS];
	istream_pkg::pc_t base_q [istream_pkg::ISTREAM_SETS];

	istream_pkg::set_ptr_t head;
	istream_pkg::set_ptr_t tail;
	istream_pkg::set_ptr_t head_plus_one;
	logic [2:0] occupancy;
	istream_pkg::parcel_idx_t offset;

	logic push;
	logic [1:0] pops;
	istream_pkg::window_mask_t raw_valid;
	istream_pkg::window_mask_t rest_valid;
	istream_pkg::parcel_cnt_t next_off;
	istream_pkg::parcel_idx_t new_offset;

	assign head_plus_one = head + istream_pkg::set_ptr_t'(1);
	assign full = (occupancy == 3'(istream_pkg::ISTREAM_SETS));
	assign read_offset = offset;

	// Chunks with no valid parcel are never stored
	assign push = enq && (|enq_mask);

	// ------------------------------------------------------------
	// Two-chunk window

	always_comb begin
		window_parcels = {parcels_q[head_plus_one], parcels_q[head]};
		window_base_PC = {base_q[head_plus_one], base_q[head]};
		raw_valid = '0;
		if (occupancy != 3'd0)
			raw_valid[istream_pkg::FETCH_WIDTH_2B-1:0] = mask_q[head];
		if (occupancy > 3'd1)
			raw_valid[istream_pkg::WINDOW_2B-1:istream_pkg::FETCH_WIDTH_2B] = mask_q[head_plus_one];
		// Hide parcels already handed out
		window_valid = raw_valid & ~((istream_pkg::window_mask_t'(1) << offset) -
			istream_pkg::window_mask_t'(1));
	end

	// ------------------------------------------------------------
	// Offset advance and chunk release

	always_comb begin
		next_off = {1'b0, offset} + (consume ? consume_count : istream_pkg::parcel_cnt_t'(0));
		rest_valid = window_valid & ~((istream_pkg::window_mask_t'(1) << next_off) -
			istream_pkg::window_mask_t'(1));
		if (|rest_valid[istream_pkg::FETCH_WIDTH_2B-1:0]) begin
			pops = 2'd0;
			new_offset = next_off[3:0];
		end
		else if (|rest_valid[istream_pkg::WINDOW_2B-1:istream_pkg::FETCH_WIDTH_2B]) begin
			// Head has nothing left, second chunk becomes head
			pops = 2'd1;
			new_offset = (next_off >= 5'd8) ? istream_pkg::parcel_idx_t'(next_off - 5'd8) : '0;
		end
		else begin
			// Whole window drained
			pops = (occupancy > 3'd1) ? 2'd2 : 2'(occupancy);
			new_offset = '0;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			head <= '0;
			tail <= '0;
			occupancy <= '0;
			offset <= '0;
		end
		else if (restart) begin
			head <= '0;
			tail <= '0;
			occupancy <= '0;
			offset <= '0;
		end
		else begin
			head <= head + istream_pkg::set_ptr_t'(pops);
			tail <= tail + istream_pkg::set_ptr_t'(push);
			occupancy <= occupancy + 3'(push) - 3'(pops);
			offset <= new_offset;
		end
	end

	// Payload write, base is the 16-byte line holding after_PC - 2
	always_ff @(posedge CLK) begin
		if (push) begin
			parcels_q[tail] <= enq_parcels;
			mask_q[tail] <= enq_mask;
			base_q[tail] <= (enq_after_PC - istream_pkg::pc_t'(2)) & ~istream_pkg::pc_t'(32'hF);
		end
	end

endmodule

// ==== hw/istream_parcel_marker.sv ====
`timescale 1ns/100ps

module istream_parcel_marker (
	input istream_pkg::window_mask_t window_valid,
	input istream_pkg::parcel_t [istream_pkg::WINDOW_2B-1:0] window_parcels,
	input istream_pkg::parcel_idx_t read_offset,

	output istream_pkg::window_mask_t start_mask,
	output istream_pkg::window_mask_t long_mask,
	output istream_pkg::parcel_idx_t [istream_pkg::WINDOW_2B-1:0] second_idx,
	output istream_pkg::window_mask_t complete_mask
);

	// ------------------------------------------------------------
	// Boundary walk over the valid parcels in stream order

	always_comb begin
		logic need_second;
		istream_pkg::parcel_idx_t first_idx;

		start_mask = '0;
		long_mask = '0;
		second_idx = '0;
		complete_mask = '0;
		need_second = 1'b0;
		first_idx = '0;

		for (int i = 0; i < istream_pkg::WINDOW_2B; i++) begin
			if (window_valid[i] && (i >= int'(read_offset))) begin
				if (need_second) begin
					// Upper half of a 32-bit instruction, may sit in the next chunk
					second_idx[first_idx] = istream_pkg::parcel_idx_t'(i);
					complete_mask[first_idx] = 1'b1;
					need_second = 1'b0;
				end
				else begin
					start_mask[i] = 1'b1;
					if (window_parcels[i][1:0] == 2'b11) begin
						long_mask[i] = 1'b1;
						need_second = 1'b1;
						first_idx = istream_pkg::parcel_idx_t'(i);
					end
					else begin
						// Compressed, complete by itself
						complete_mask[i] = 1'b1;
					end
				end
			end
		end
	end

endmodule

// ==== hw/istream_way_select.sv ====
`timescale 1ns/100ps

module istream_way_select (
	input istream_pkg::window_mask_t window_valid,
	input istream_pkg::parcel_t [istream_pkg::WINDOW_2B-1:0] window_parcels,
	input istream_pkg::pc_t [1:0] window_base_PC,
	input istream_pkg::parcel_idx_t read_offset,

	input istream_pkg::window_mask_t start_mask,
	input istream_pkg::window_mask_t long_mask,
	input istream_pkg::parcel_idx_t [istream_pkg::WINDOW_2B-1:0] second_idx,
	input istream_pkg::window_mask_t complete_mask,

	output logic valid_SDEQ,
	output istream_pkg::way_mask_t valid_by_way_SDEQ,
	output istream_pkg::way_mask_t uncompressed_by_way_SDEQ,
	output istream_pkg::parcel_t [istream_pkg::WAYS-1:0][1:0] instr_2B_by_way_by_chunk_SDEQ,
	output istream_pkg::pc_t [istream_pkg::WAYS-1:0] PC_by_way_SDEQ,
	output istream_pkg::parcel_cnt_t consume_count
);

	// ------------------------------------------------------------
	// Fill ways in order from the oldest complete start

	always_comb begin
		int way;
		istream_pkg::parcel_cnt_t end_pos;
		istream_pkg::pc_t chunk_base;

		valid_by_way_SDEQ = '0;
		uncompressed_by_way_SDEQ = '0;
		instr_2B_by_way_by_chunk_SDEQ = '0;
		PC_by_way_SDEQ = '0;
		end_pos = {1'b0, read_offset};
		way = 0;
		chunk_base = '0;

		for (int i = 0; i < istream_pkg::WINDOW_2B; i++) begin
			// Starts only ever fall in valid parcels
			if (window_valid[i] && start_mask[i] && complete_mask[i] &&
				(way < istream_pkg::WAYS)) begin
				chunk_base = (i >= istream_pkg::FETCH_WIDTH_2B) ?
					window_base_PC[1] : window_base_PC[0];
				valid_by_way_SDEQ[way] = 1'b1;
				uncompressed_by_way_SDEQ[way] = long_mask[i];
				instr_2B_by_way_by_chunk_SDEQ[way][0] = window_parcels[i];
				PC_by_way_SDEQ[way] = chunk_base +
					istream_pkg::pc_t'(2 * (i % istream_pkg::FETCH_WIDTH_2B));
				if (long_mask[i]) begin
					instr_2B_by_way_by_chunk_SDEQ[way][1] = window_parcels[second_idx[i]];
					end_pos = {1'b0, second_idx[i]} + istream_pkg::parcel_cnt_t'(1);
				end
				else begin
					end_pos = istream_pkg::parcel_cnt_t'(i + 1);
				end
				way++;
			end
		end

		// Counted from the read offset, skipped gaps included
		consume_count = end_pos - {1'b0, read_offset};
	end

	assign valid_SDEQ = |valid_by_way_SDEQ;

endmodule

// ==== hw/istream.sv ====
`timescale 1ns/100ps

module istream (
	input logic CLK,
	input logic nRST,

	// Enqueue side
	input logic valid_SENQ,
	input istream_pkg::parcel_mask_t valid_by_fetch_2B_SENQ,
	input istream_pkg::parcel_t [istream_pkg::FETCH_WIDTH_2B-1:0] instr_2B_by_fetch_2B_SENQ,
	input istream_pkg::pc_t after_PC_SENQ,
	output logic stall_SENQ,

	// Dequeue side
	output logic valid_SDEQ,
	output istream_pkg::way_mask_t valid_by_way_SDEQ,
	output istream_pkg::way_mask_t uncompressed_by_way_SDEQ,
	output istream_pkg::parcel_t [istream_pkg::WAYS-1:0][1:0] instr_2B_by_way_by_chunk_SDEQ,
	output istream_pkg::pc_t [istream_pkg::WAYS-1:0] PC_by_way_SDEQ,
	input logic stall_SDEQ,

	input logic restart
);

	logic full;
	istream_pkg::window_mask_t window_valid;
	istream_pkg::parcel_t [istream_pkg::WINDOW_2B-1:0] window_parcels;
	istream_pkg::pc_t [1:0] window_base_PC;
	istream_pkg::parcel_idx_t read_offset;

	istream_pkg::window_mask_t start_mask;
	istream_pkg::window_mask_t long_mask;
	istream_pkg::parcel_idx_t [istream_pkg::WINDOW_2B-1:0] second_idx;
	istream_pkg::window_mask_t complete_mask;
	istream_pkg::parcel_cnt_t consume_count;

	// Back-pressure is simply queue full
	assign stall_SENQ = full;

	istream_chunk_queue chunk_queue_i (
		.CLK(CLK),
		.nRST(nRST),
		.restart(restart),
		.enq(valid_SENQ && !full),
		.enq_mask(valid_by_fetch_2B_SENQ),
		.enq_parcels(instr_2B_by_fetch_2B_SENQ),
		.enq_after_PC(after_PC_SENQ),
		.consume(valid_SDEQ && !stall_SDEQ),
		.consume_count(consume_count),
		.full(full),
		.window_valid(window_valid),
		.window_parcels(window_parcels),
		.window_base_PC(window_base_PC),
		.read_offset(read_offset)
	);

	istream_parcel_marker parcel_marker_i (
		.window_valid(window_valid),
		.window_parcels(window_parcels),
		.read_offset(read_offset),
		.start_mask(start_mask),
		.long_mask(long_mask),
		.second_idx(second_idx),
		.complete_mask(complete_mask)
	);

	istream_way_select way_select_i (
		.window_valid(window_valid),
		.window_parcels(window_parcels),
		.window_base_PC(window_base_PC),
		.read_offset(read_offset),
		.start_mask(start_mask),
		.long_mask(long_mask),
		.second_idx(second_idx),
		.complete_mask(complete_mask),
		.valid_SDEQ(valid_SDEQ),
		.valid_by_way_SDEQ(valid_by_way_SDEQ),
		.uncompressed_by_way_SDEQ(uncompressed_by_way_SDEQ),
		.instr_2B_by_way_by_chunk_SDEQ(instr_2B_by_way_by_chunk_SDEQ),
		.PC_by_way_SDEQ(PC_by_way_SDEQ),
		.consume_count(consume_count)
	);

endmodule

// ==== hw/istream_wrapper.sv ====
`timescale 1ns/100ps

module istream_wrapper (
	input logic CLK,
	input logic nRST,

	// Enqueue side
	input logic next_valid_SENQ,
	input istream_pkg::parcel_mask_t next_valid_by_fetch_2B_SENQ,
	input istream_pkg::parcel_t [istream_pkg::FETCH_WIDTH_2B-1:0] next_instr_2B_by_fetch_2B_SENQ,
	input istream_pkg::pc_t next_after_PC_SENQ,
	output logic last_stall_SENQ,

	// Dequeue side
	output logic last_valid_SDEQ,
	output istream_pkg::way_mask_t last_valid_by_way_SDEQ,
	output istream_pkg::way_mask_t last_uncompressed_by_way_SDEQ,
	output istream_pkg::parcel_t [istream_pkg::WAYS-1:0][1:0] last_instr_2B_by_way_by_chunk_SDEQ,
	output istream_pkg::pc_t [istream_pkg::WAYS-1:0] last_PC_by_way_SDEQ,
	input logic next_stall_SDEQ,

	input logic next_restart
);

	// ------------------------------------------------------------
	// Signals on the istream side of the flops

	logic valid_SENQ;
	istream_pkg::parcel_mask_t valid_by_fetch_2B_SENQ;
	istream_pkg::parcel_t [istream_pkg::FETCH_WIDTH_2B-1:0] instr_2B_by_fetch_2B_SENQ;
	istream_pkg::pc_t after_PC_SENQ;
	logic stall_SENQ;

	logic valid_SDEQ;
	istream_pkg::way_mask_t valid_by_way_SDEQ;
	istream_pkg::way_mask_t uncompressed_by_way_SDEQ;
	istream_pkg::parcel_t [istream_pkg::WAYS-1:0][1:0] instr_2B_by_way_by_chunk_SDEQ;
	istream_pkg::pc_t [istream_pkg::WAYS-1:0] PC_by_way_SDEQ;
	logic stall_SDEQ;

	logic restart;

	istream wrapped_module (.*);

	// ------------------------------------------------------------
	// One flop stage on every port

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			valid_SENQ <= '0;
			valid_by_fetch_2B_SENQ <= '0;
			instr_2B_by_fetch_2B_SENQ <= '0;
			after_PC_SENQ <= '0;
			last_stall_SENQ <= '0;
			last_valid_SDEQ <= '0;
			last_valid_by_way_SDEQ <= '0;
			last_uncompressed_by_way_SDEQ <= '0;
			last_instr_2B_by_way_by_chunk_SDEQ <= '0;
			last_PC_by_way_SDEQ <= '0;
			stall_SDEQ <= '0;
			restart <= '0;
		end
		else begin
			// Inputs
			valid_SENQ <= next_valid_SENQ;
			valid_by_fetch_2B_SENQ <= next_valid_by_fetch_2B_SENQ;
			instr_2B_by_fetch_2B_SENQ <= next_instr_2B_by_fetch_2B_SENQ;
			after_PC_SENQ <= next_after_PC_SENQ;
			stall_SDEQ <= next_stall_SDEQ;
			restart <= next_restart;
			// Outputs
			last_stall_SENQ <= stall_SENQ;
			last_valid_SDEQ <= valid_SDEQ;
			last_valid_by_way_SDEQ <= valid_by_way_SDEQ;
			last_uncompressed_by_way_SDEQ <= uncompressed_by_way_SDEQ;
			last_instr_2B_by_way_by_chunk_SDEQ <= instr_2B_by_way_by_chunk_SDEQ;
			last_PC_by_way_SDEQ <= PC_by_way_SDEQ;
		end
	end

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic CLK,
	output logic nRST
);

	// 40 ns period
	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// Two clock cycles of reset
	initial begin
		nRST = 1'b0;
		#80 nRST = 1'b1;
	end

endmodule

// ==== testbench/tb_istream.sv ====
`timescale 1ns/100ps

module tb_istream;

	logic CLK;
	logic nRST;
	logic next_valid_SENQ;
	istream_pkg::parcel_mask_t next_valid_by_fetch_2B_SENQ;
	istream_pkg::parcel_t [istream_pkg::FETCH_WIDTH_2B-1:0] next_instr_2B_by_fetch_2B_SENQ;
	istream_pkg::pc_t next_after_PC_SENQ;
	logic last_stall_SENQ;
	logic last_valid_SDEQ;
	istream_pkg::way_mask_t last_valid_by_way_SDEQ;
	istream_pkg::way_mask_t last_uncompressed_by_way_SDEQ;
	istream_pkg::parcel_t [istream_pkg::WAYS-1:0][1:0] last_instr_2B_by_way_by_chunk_SDEQ;
	istream_pkg::pc_t [istream_pkg::WAYS-1:0] last_PC_by_way_SDEQ;
	logic next_stall_SDEQ;
	logic next_restart;

	// Values staged for the next falling edge
	logic drive_valid;
	logic drive_stall;
	logic drive_restart;
	istream_pkg::parcel_mask_t drive_mask;
	istream_pkg::parcel_t [istream_pkg::FETCH_WIDTH_2B-1:0] drive_parcels;
	istream_pkg::pc_t drive_pc;
	istream_pkg::pc_t drive_line;
	istream_pkg::pc_t line_addr;

	// Offers and stalls of the last two cycles
	// Index 1 holds the older one
	logic off_valid [2];
	istream_pkg::parcel_mask_t off_mask [2];
	istream_pkg::parcel_t [istream_pkg::FETCH_WIDTH_2B-1:0] off_parcels [2];
	istream_pkg::pc_t off_line [2];
	logic stall_line [2];

	// Expected instruction stream
	logic [15:0] exp_first [$];
	logic [15:0] exp_second [$];
	logic [31:0] exp_pc [$];
	bit exp_long [$];
	bit pending_long;
	logic [15:0] pending_first;
	logic [31:0] pending_pc;

	int value_errors;
	int other_errors;
	int accepted_cnt;
	int held_ways;
	bit check_en;

	tb_clock clock_i (.CLK(CLK), .nRST(nRST));

	istream_wrapper dut_i (.*);

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
		input logic [31:0] got_val);
		$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_val, got_val);
		value_errors++;
	endtask

	// ------------------------------------------------------------
	// Reference model

	task automatic accept_chunk(input istream_pkg::parcel_mask_t mask,
		input istream_pkg::parcel_t [istream_pkg::FETCH_WIDTH_2B-1:0] parcels,
		input istream_pkg::pc_t line_base);
		for (int i = 0; i < istream_pkg::FETCH_WIDTH_2B; i++) begin
			if (mask[i]) begin
				if (pending_long) begin
					// Upper half may come from a later chunk
					exp_first.push_back(pending_first);
					exp_second.push_back(parcels[i]);
					exp_pc.push_back(pending_pc);
					exp_long.push_back(1'b1);
					pending_long = 1'b0;
				end
				else if (parcels[i][1:0] == 2'b11) begin
					pending_long = 1'b1;
					pending_first = parcels[i];
					pending_pc = line_base + 32'(2 * i);
				end
				else begin
					exp_first.push_back(parcels[i]);
					exp_second.push_back(16'h0000);
					exp_pc.push_back(line_base + 32'(2 * i));
					exp_long.push_back(1'b0);
				end
			end
		end
	endtask

	task automatic clear_model();
		exp_first.delete();
		exp_second.delete();
		exp_pc.delete();
		exp_long.delete();
		pending_long = 1'b0;
		held_ways = 0;
	endtask

	// ------------------------------------------------------------
	// Bundle check against the head of the model stream

	task automatic check_bundle();
		int n;
		istream_pkg::way_mask_t holes;
		holes = last_valid_by_way_SDEQ & (last_valid_by_way_SDEQ + 4'd1);
		n = $countones(last_valid_by_way_SDEQ);
		if (holes != '0) begin
			$display("Error at %0t ns: bundle ways are not filled from way 0", $time);
			other_errors++;
		end
		if (n > exp_first.size()) begin
			$display("Error at %0t ns: bundle has %0d instructions but only %0d are expected",
				$time, n, exp_first.size());
			other_errors++;
			n = exp_first.size();
		end
		for (int w = 0; w < n; w++) begin
			if (last_uncompressed_by_way_SDEQ[w] != exp_long[w])
				report_mismatch($sformatf("last_uncompressed_by_way_SDEQ[%0d]", w),
					32'(exp_long[w]), 32'(last_uncompressed_by_way_SDEQ[w]));
			if (last_instr_2B_by_way_by_chunk_SDEQ[w][0] != exp_first[w])
				report_mismatch($sformatf("last_instr_2B_by_way_by_chunk_SDEQ[%0d][0]", w),
					32'(exp_first[w]), 32'(last_instr_2B_by_way_by_chunk_SDEQ[w][0]));
			if (exp_long[w] && last_instr_2B_by_way_by_chunk_SDEQ[w][1] != exp_second[w])
				report_mismatch($sformatf("last_instr_2B_by_way_by_chunk_SDEQ[%0d][1]", w),
					32'(exp_second[w]), 32'(last_instr_2B_by_way_by_chunk_SDEQ[w][1]));
			if (last_PC_by_way_SDEQ[w] != exp_pc[w])
				report_mismatch($sformatf("last_PC_by_way_SDEQ[%0d]", w),
					exp_pc[w], last_PC_by_way_SDEQ[w]);
		end
		// Consumed only if the stall driven two cycles earlier was low
		if (!stall_line[1]) begin
			for (int w = 0; w < n; w++) begin
				void'(exp_first.pop_front());
				void'(exp_second.pop_front());
				void'(exp_pc.pop_front());
				void'(exp_long.pop_front());
			end
		end
	endtask

	// ------------------------------------------------------------
	// Per falling edge the checks come first, then new inputs

	task automatic advance_cycle();
		int shown;
		logic any_way;
		@(negedge CLK);
		if (off_valid[1] && !last_stall_SENQ) begin
			accept_chunk(off_mask[1], off_parcels[1], off_line[1]);
			accepted_cnt++;
		end
		if (check_en) begin
			any_way = (last_valid_by_way_SDEQ != '0);
			if (last_valid_SDEQ !== any_way)
				report_mismatch("last_valid_SDEQ", 32'(any_way), 32'(last_valid_SDEQ));
			shown = last_valid_SDEQ ? $countones(last_valid_by_way_SDEQ) : 0;
			if (shown < held_ways) begin
				$display("Error at %0t ns: a stalled bundle lost instructions", $time);
				other_errors++;
			end
			if (last_valid_SDEQ)
				check_bundle();
			held_ways = stall_line[1] ? shown : 0;
		end
		off_valid[1] = off_valid[0];
		off_mask[1] = off_mask[0];
		off_parcels[1] = off_parcels[0];
		off_line[1] = off_line[0];
		stall_line[1] = stall_line[0];
		off_valid[0] = drive_valid;
		off_mask[0] = drive_mask;
		off_parcels[0] = drive_parcels;
		off_line[0] = drive_line;
		stall_line[0] = drive_stall;
		next_valid_SENQ = drive_valid;
		next_valid_by_fetch_2B_SENQ = drive_mask;
		next_instr_2B_by_fetch_2B_SENQ = drive_parcels;
		next_after_PC_SENQ = drive_pc;
		next_stall_SDEQ = drive_stall;
		next_restart = drive_restart;
	endtask

	// Random chunk from the next fetch line
	task automatic make_chunk(input bit dense);
		istream_pkg::parcel_t p;
		drive_mask = istream_pkg::parcel_mask_t'($urandom);
		if (($urandom % 8) == 0)
			drive_mask = 8'hFF;
		if (dense && drive_mask == '0)
			drive_mask = 8'h01;
		for (int i = 0; i < istream_pkg::FETCH_WIDTH_2B; i++) begin
			p = 16'($urandom);
			if (($urandom % 3) == 0)
				p[1:0] = 2'b11;
			drive_parcels[i] = p;
		end
		drive_line = line_addr;
		drive_pc = line_addr + 32'd2 + 32'(2 * ($urandom % 8));
		line_addr = line_addr + 32'd16;
	endtask

	task automatic run_traffic(input int cycles, input int stall_pct);
		for (int c = 0; c < cycles; c++) begin
			drive_valid = (($urandom % 10) < 7);
			drive_stall = (($urandom % 100) < stall_pct);
			make_chunk(1'b0);
			advance_cycle();
		end
	endtask

	task automatic drain();
		int guard;
		drive_valid = 1'b0;
		drive_stall = 1'b0;
		repeat (3) advance_cycle();
		guard = 0;
		while (exp_first.size() != 0 && guard < 60) begin
			advance_cycle();
			guard++;
		end
		if (exp_first.size() != 0) begin
			$display("Error at %0t ns: timeout, %0d instructions never came out",
				$time, exp_first.size());
			other_errors++;
		end
	endtask

	task automatic apply_restart();
		drive_valid = 1'b0;
		drive_stall = 1'b0;
		repeat (3) advance_cycle();
		check_en = 1'b0;
		drive_restart = 1'b1;
		advance_cycle();
		drive_restart = 1'b0;
		repeat (3) advance_cycle();
		if (last_valid_SDEQ)
			report_mismatch("last_valid_SDEQ", 32'd0, 32'(last_valid_SDEQ));
		clear_model();
		check_en = 1'b1;
	endtask

	// Consumer held off until the queue reports full
	task automatic fill_queue();
		int guard;
		accepted_cnt = 0;
		drive_valid = 1'b1;
		drive_stall = 1'b1;
		guard = 0;
		while (!last_stall_SENQ && guard < 20) begin
			make_chunk(1'b1);
			advance_cycle();
			guard++;
		end
		if (!last_stall_SENQ) begin
			$display("Error at %0t ns: timeout, queue never reported full", $time);
			other_errors++;
		end
		else if (accepted_cnt != istream_pkg::ISTREAM_SETS) begin
			$display("Error at %0t ns: queue full after %0d accepted chunks", $time, accepted_cnt);
			other_errors++;
		end
		repeat (6) begin
			make_chunk(1'b1);
			advance_cycle();
			if (!last_stall_SENQ)
				report_mismatch("last_stall_SENQ", 32'd1, 32'(last_stall_SENQ));
		end
	endtask

	initial begin
		int guard;
		next_valid_SENQ = 1'b0;
		next_valid_by_fetch_2B_SENQ = '0;
		next_instr_2B_by_fetch_2B_SENQ = '0;
		next_after_PC_SENQ = '0;
		next_stall_SDEQ = 1'b0;
		next_restart = 1'b0;
		drive_valid = 1'b0;
		drive_stall = 1'b0;
		drive_restart = 1'b0;
		drive_mask = '0;
		drive_parcels = '0;
		drive_pc = '0;
		drive_line = '0;
		line_addr = 32'h0000_1000;
		for (int i = 0; i < 2; i++) begin
			off_valid[i] = 1'b0;
			off_mask[i] = '0;
			off_parcels[i] = '0;
			off_line[i] = '0;
			stall_line[i] = 1'b0;
		end
		value_errors = 0;
		other_errors = 0;
		accepted_cnt = 0;
		check_en = 1'b0;
		clear_model();
		void'($urandom(32'h05989947));

		guard = 0;
		while (nRST !== 1'b1 && guard < 10) begin
			@(posedge CLK);
			guard++;
		end
		if (nRST !== 1'b1) begin
			$display("Error at %0t ns: timeout, reset was never released", $time);
			other_errors++;
		end
		@(negedge CLK);

		// Outputs straight after reset
		if (last_stall_SENQ !== 1'b0)
			report_mismatch("last_stall_SENQ", 32'd0, 32'(last_stall_SENQ));
		if (last_valid_SDEQ !== 1'b0)
			report_mismatch("last_valid_SDEQ", 32'd0, 32'(last_valid_SDEQ));
		if (last_valid_by_way_SDEQ !== '0)
			report_mismatch("last_valid_by_way_SDEQ", 32'd0, 32'(last_valid_by_way_SDEQ));
		if (last_uncompressed_by_way_SDEQ !== '0)
			report_mismatch("last_uncompressed_by_way_SDEQ", 32'd0,
				32'(last_uncompressed_by_way_SDEQ));
		for (int w = 0; w < istream_pkg::WAYS; w++) begin
			if (last_PC_by_way_SDEQ[w] !== '0)
				report_mismatch($sformatf("last_PC_by_way_SDEQ[%0d]", w), 32'd0,
					last_PC_by_way_SDEQ[w]);
			if (last_instr_2B_by_way_by_chunk_SDEQ[w] !== '0)
				report_mismatch($sformatf("last_instr_2B_by_way_by_chunk_SDEQ[%0d]", w), 32'd0,
					last_instr_2B_by_way_by_chunk_SDEQ[w]);
		end

		check_en = 1'b1;
		run_traffic(600, 30);
		drain();
		apply_restart();
		fill_queue();
		drain();
		// Restart with a well filled queue
		run_traffic(200, 70);
		apply_restart();
		run_traffic(300, 25);
		drain();

		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("STATUS: PASS");
		end
		else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
hw/istream_pkg.sv
hw/istream_chunk_queue.sv
hw/istream_parcel_marker.sv
hw/istream_way_select.sv
hw/istream.sv
hw/istream_wrapper.sv
testbench/tb_clock.sv
testbench/tb_istream.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps
TOP      = tb_istream
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
